//--- verilog/narrator_pkg.sv
`default_nettype none
package narrator_pkg;

  // ========================================
  // Widths with a meaning
  // ========================================
  typedef logic [22:0]        flash_addr_t;
  typedef logic [31:0]        flash_word_t;
  typedef logic signed [7:0]  sample_t;
  typedef logic [3:0]         phoneme_id_t;
  typedef logic [15:0]        rate_div_t;

  // Samples packed into one flash word, byte 0 plays first
  localparam int SAMPLES_PER_WORD = 4;

  // One word request from the sequencer to the flash reader
  typedef struct packed {
    flash_addr_t addr;
    logic        silent;
    logic        last;
  } word_req_t;

  // One word handed from the flash reader to the unpacker
  typedef struct packed {
    flash_word_t data;
    logic        last;
  } word_beat_t;

  typedef struct packed {
    flash_addr_t start_addr;
    logic [7:0]  word_count;
    logic        silent;
  } phoneme_entry_t;

  // Entry i starts at word 64*i, length 2 + i%4 words, entry 0 is silence
  localparam phoneme_entry_t PHONEME_TABLE [16] = '{
    '{23'd0,   8'd2, 1'b1},
    '{23'd64,  8'd3, 1'b0},
    '{23'd128, 8'd4, 1'b0},
    '{23'd192, 8'd5, 1'b0},
    '{23'd256, 8'd2, 1'b0},
    '{23'd320, 8'd3, 1'b0},
    '{23'd384, 8'd4, 1'b0},
    '{23'd448, 8'd5, 1'b0},
    '{23'd512, 8'd2, 1'b0},
    '{23'd576, 8'd3, 1'b0},
    '{23'd640, 8'd4, 1'b0},
    '{23'd704, 8'd5, 1'b0},
    '{23'd768, 8'd2, 1'b0},
    '{23'd832, 8'd3, 1'b0},
    '{23'd896, 8'd4, 1'b0},
    '{23'd960, 8'd5, 1'b0}
  };

endpackage
`default_nettype wire

//--- verilog/sample_rate_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
module sample_rate_ctrl #(
  parameter narrator_pkg::rate_div_t SAMPLE_DIV_DEFAULT = 16'd3472,
  parameter narrator_pkg::rate_div_t SAMPLE_DIV_STEP    = 16'd100,
  parameter narrator_pkg::rate_div_t SAMPLE_DIV_MIN     = 16'd1000,
  parameter narrator_pkg::rate_div_t SAMPLE_DIV_MAX     = 16'd10000
) (
  input  wire                     CLK_50M,
  input  wire                     rst_n,
  input  wire                     speed_up,
  input  wire                     speed_down,
  input  wire                     speed_reset,
  output narrator_pkg::rate_div_t sample_divisor,
  output logic                    sample_tick
);
  import narrator_pkg::*;

  // One extra bit so the clamp compares cannot wrap
  localparam logic [$bits(rate_div_t):0] FASTER_FLOOR =
    {1'b0, SAMPLE_DIV_MIN} + {1'b0, SAMPLE_DIV_STEP};

  logic [$bits(rate_div_t):0] slower_wide;
  rate_div_t                  div_next;
  rate_div_t                  tick_cnt;

  assign slower_wide = {1'b0, sample_divisor} + {1'b0, SAMPLE_DIV_STEP};

  // Priority is reset, then up, then down
  always_comb
  begin
    div_next = sample_divisor;
    if (speed_reset)
      div_next = SAMPLE_DIV_DEFAULT;
    else if (speed_up)
      div_next = ({1'b0, sample_divisor} >= FASTER_FLOOR) ?
                 rate_div_t'(sample_divisor - SAMPLE_DIV_STEP) : SAMPLE_DIV_MIN;
    else if (speed_down)
      div_next = (slower_wide > {1'b0, SAMPLE_DIV_MAX}) ?
                 SAMPLE_DIV_MAX : slower_wide[$bits(rate_div_t)-1:0];
  end

  // >= so a shrinking divisor never leaves the counter stranded above it
  assign sample_tick = (tick_cnt >= rate_div_t'(sample_divisor - 1'b1));

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      sample_divisor <= SAMPLE_DIV_DEFAULT;
      tick_cnt       <= '0;
    end
    else
    begin
      sample_divisor <= div_next;
      tick_cnt       <= sample_tick ? '0 : rate_div_t'(tick_cnt + 1'b1);
    end
  end

endmodule
`default_nettype wire

//--- verilog/phoneme_sequencer.sv
`timescale 1ns/100ps
`default_nettype none
module phoneme_sequencer #(
  parameter int WORD_BUF_DEPTH = 2
) (
  input  wire                            CLK_50M,
  input  wire                            rst_n,
  input  wire                            phoneme_valid,
  input  wire narrator_pkg::phoneme_id_t phoneme_id,
  output logic                           phoneme_ready,
  output narrator_pkg::word_req_t        req,
  output logic                           req_valid,
  input  wire                            credit_return
);
  import narrator_pkg::*;

  typedef enum logic {
    SEQ_IDLE,
    SEQ_ISSUE
  } seq_state_t;

  localparam int CREDIT_W = $clog2(WORD_BUF_DEPTH + 1);

  seq_state_t          state;
  logic [CREDIT_W-1:0] credit_cnt;
  phoneme_entry_t      entry;
  logic                accept;
  logic                last_word;
  flash_addr_t         word_addr;
  logic [7:0]          words_left;
  logic                silent_q;

  assign entry         = PHONEME_TABLE[phoneme_id];
  assign phoneme_ready = (state == SEQ_IDLE);
  assign accept        = phoneme_valid && phoneme_ready;
  assign last_word     = (words_left == 8'd1);

  // A request only goes out while a credit is held
  assign req_valid = (state == SEQ_ISSUE) && (credit_cnt != '0);
  assign req       = '{addr: word_addr, silent: silent_q, last: last_word};

  // ========================================
  // Credit counter
  // ========================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      credit_cnt <= CREDIT_W'(WORD_BUF_DEPTH);
    else if (req_valid && !credit_return)
      credit_cnt <= credit_cnt - 1'b1;
    else if (credit_return && !req_valid)
      credit_cnt <= credit_cnt + 1'b1;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      state <= SEQ_IDLE;
    else
    begin
      case (state)
        SEQ_IDLE:
          if (accept)
            state <= SEQ_ISSUE;
        SEQ_ISSUE:
          if (req_valid && last_word)
            state <= SEQ_IDLE;
        default:
          state <= SEQ_IDLE;
      endcase
    end
  end

  // Table lookup on accept, then one word per spent credit
  always_ff @(posedge CLK_50M)
  begin
    if (accept)
    begin
      word_addr  <= entry.start_addr;
      words_left <= entry.word_count;
      silent_q   <= entry.silent;
    end
    else if (req_valid)
    begin
      word_addr  <= word_addr + 1'b1;
      words_left <= words_left - 1'b1;
    end
  end

endmodule
`default_nettype wire

//--- verilog/flash_word_reader.sv
`timescale 1ns/100ps
`default_nettype none
module flash_word_reader #(
  parameter int WORD_BUF_DEPTH = 2
) (
  input  wire                            CLK_50M,
  input  wire                            rst_n,
  input  wire narrator_pkg::word_req_t   req,
  input  wire                            req_valid,
  output logic                           flash_read,
  output narrator_pkg::flash_addr_t      flash_address,
  input  wire                            flash_waitrequest,
  input  wire narrator_pkg::flash_word_t flash_readdata,
  input  wire                            flash_readdatavalid,
  output narrator_pkg::word_beat_t       beat,
  output logic                           beat_valid
);
  import narrator_pkg::*;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_REQUEST,
    RD_WAIT_DATA
  } rd_state_t;

  localparam int PTR_W   = (WORD_BUF_DEPTH > 1) ? $clog2(WORD_BUF_DEPTH) : 1;
  localparam int COUNT_W = $clog2(WORD_BUF_DEPTH + 1);

  word_req_t          req_q [WORD_BUF_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [COUNT_W-1:0] q_count;
  word_req_t          head;
  logic               pop;
  logic               got_data;
  logic               last_q;
  rd_state_t          state;

  assign head       = req_q[rd_ptr];
  assign pop        = (state == RD_IDLE) && (q_count != '0);
  assign flash_read = (state == RD_REQUEST);
  // Data may land in the accept cycle or any cycle after it
  assign got_data   = flash_readdatavalid &&
                      ((state == RD_WAIT_DATA) || (flash_read && !flash_waitrequest));

  always_ff @(posedge CLK_50M)
  begin
    if (req_valid)
      req_q[wr_ptr] <= req;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end
    else
    begin
      if (req_valid)
        wr_ptr <= (wr_ptr == PTR_W'(WORD_BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(WORD_BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (req_valid && !pop)
        q_count <= q_count + 1'b1;
      else if (pop && !req_valid)
        q_count <= q_count - 1'b1;
    end
  end

  // ========================================
  // Read FSM, one read in flight
  // ========================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      state      <= RD_IDLE;
      beat_valid <= 1'b0;
    end
    else
    begin
      beat_valid <= got_data || (pop && head.silent);
      case (state)
        RD_IDLE:
          if (pop && !head.silent)
            state <= RD_REQUEST;
        RD_REQUEST:
          if (!flash_waitrequest)
            state <= got_data ? RD_IDLE : RD_WAIT_DATA;
        RD_WAIT_DATA:
          if (got_data)
            state <= RD_IDLE;
        default:
          state <= RD_IDLE;
      endcase
    end
  end

  // Silent words come out as zero without touching flash
  always_ff @(posedge CLK_50M)
  begin
    if (pop)
    begin
      flash_address <= head.addr;
      last_q        <= head.last;
      beat          <= '{data: '0, last: head.last};
    end
    else if (got_data)
      beat <= '{data: flash_readdata, last: last_q};
  end

endmodule
`default_nettype wire

//--- verilog/sample_unpacker.sv
`timescale 1ns/100ps
`default_nettype none
module sample_unpacker #(
  parameter int WORD_BUF_DEPTH = 2
) (
  input  wire                           CLK_50M,
  input  wire                           rst_n,
  input  wire narrator_pkg::word_beat_t beat,
  input  wire                           beat_valid,
  input  wire                           sample_tick,
  output narrator_pkg::sample_t         sample_out,
  output logic                          sample_strobe,
  output logic                          phoneme_done,
  output logic                          credit_return
);
  import narrator_pkg::*;

  localparam int PTR_W      = (WORD_BUF_DEPTH > 1) ? $clog2(WORD_BUF_DEPTH) : 1;
  localparam int COUNT_W    = $clog2(WORD_BUF_DEPTH + 1);
  localparam int BYTE_IDX_W = $clog2(SAMPLES_PER_WORD);

  word_beat_t            word_q [WORD_BUF_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [COUNT_W-1:0]    q_count;
  logic [BYTE_IDX_W-1:0] byte_idx;
  word_beat_t            head;
  logic                  emit;
  logic                  word_end;

  assign head     = word_q[rd_ptr];
  // Ticks that find the queue empty are dropped
  assign emit     = sample_tick && (q_count != '0);
  assign word_end = emit && (byte_idx == BYTE_IDX_W'(SAMPLES_PER_WORD - 1));

  always_ff @(posedge CLK_50M)
  begin
    if (beat_valid)
      word_q[wr_ptr] <= beat;
  end

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      q_count       <= '0;
      byte_idx      <= '0;
      sample_strobe <= 1'b0;
      phoneme_done  <= 1'b0;
      credit_return <= 1'b0;
    end
    else
    begin
      sample_strobe <= emit;
      phoneme_done  <= word_end && head.last;
      // Word slot is free again, hand the credit back
      credit_return <= word_end;
      if (emit)
        byte_idx <= word_end ? '0 : byte_idx + 1'b1;
      if (beat_valid)
        wr_ptr <= (wr_ptr == PTR_W'(WORD_BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (word_end)
        rd_ptr <= (rd_ptr == PTR_W'(WORD_BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (beat_valid && !word_end)
        q_count <= q_count + 1'b1;
      else if (word_end && !beat_valid)
        q_count <= q_count - 1'b1;
    end
  end

  // Byte 0 in bits 7:0 goes out first
  always_ff @(posedge CLK_50M)
  begin
    if (emit)
      sample_out <= head.data[byte_idx * $bits(sample_t) +: $bits(sample_t)];
  end

endmodule
`default_nettype wire

//--- verilog/narrator_top.sv
`timescale 1ns/100ps
`default_nettype none
module narrator_top #(
  parameter narrator_pkg::rate_div_t SAMPLE_DIV_DEFAULT = 16'd3472,
  parameter narrator_pkg::rate_div_t SAMPLE_DIV_STEP    = 16'd100,
  parameter narrator_pkg::rate_div_t SAMPLE_DIV_MIN     = 16'd1000,
  parameter narrator_pkg::rate_div_t SAMPLE_DIV_MAX     = 16'd10000,
  parameter int                      WORD_BUF_DEPTH     = 2
) (
  input  wire                            CLK_50M,
  input  wire                            rst_n,
  input  wire                            phoneme_valid,
  input  wire narrator_pkg::phoneme_id_t phoneme_id,
  output logic                           phoneme_ready,
  output logic                           flash_read,
  output narrator_pkg::flash_addr_t      flash_address,
  input  wire                            flash_waitrequest,
  input  wire narrator_pkg::flash_word_t flash_readdata,
  input  wire                            flash_readdatavalid,
  input  wire                            speed_up,
  input  wire                            speed_down,
  input  wire                            speed_reset,
  output narrator_pkg::sample_t          sample_out,
  output logic                           sample_strobe,
  output logic                           phoneme_done,
  output narrator_pkg::rate_div_t        sample_divisor
);
  import narrator_pkg::*;

  // ========================================
  // Pipeline nets
  // ========================================
  word_req_t  req;
  logic       req_valid;
  word_beat_t beat;
  logic       beat_valid;
  logic       credit_return;
  logic       sample_tick;

  sample_rate_ctrl #(
    .SAMPLE_DIV_DEFAULT (SAMPLE_DIV_DEFAULT),
    .SAMPLE_DIV_STEP    (SAMPLE_DIV_STEP),
    .SAMPLE_DIV_MIN     (SAMPLE_DIV_MIN),
    .SAMPLE_DIV_MAX     (SAMPLE_DIV_MAX)
  ) rate_ctrl (
    .CLK_50M        (CLK_50M),
    .rst_n          (rst_n),
    .speed_up       (speed_up),
    .speed_down     (speed_down),
    .speed_reset    (speed_reset),
    .sample_divisor (sample_divisor),
    .sample_tick    (sample_tick)
  );

  // Phoneme number to word requests, paced by credits
  phoneme_sequencer #(.WORD_BUF_DEPTH(WORD_BUF_DEPTH)) sequencer (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .phoneme_valid (phoneme_valid),
    .phoneme_id    (phoneme_id),
    .phoneme_ready (phoneme_ready),
    .req           (req),
    .req_valid     (req_valid),
    .credit_return (credit_return)
  );

  flash_word_reader #(.WORD_BUF_DEPTH(WORD_BUF_DEPTH)) reader (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .req                 (req),
    .req_valid           (req_valid),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .beat                (beat),
    .beat_valid          (beat_valid)
  );

  // Word to bytes at the sample rate, credits go back upstream
  sample_unpacker #(.WORD_BUF_DEPTH(WORD_BUF_DEPTH)) unpacker (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .beat          (beat),
    .beat_valid    (beat_valid),
    .sample_tick   (sample_tick),
    .sample_out    (sample_out),
    .sample_strobe (sample_strobe),
    .phoneme_done  (phoneme_done),
    .credit_return (credit_return)
  );

endmodule
`default_nettype wire

//--- sim/narrator_assertions.sv
`timescale 1ns/100ps
`default_nettype none
module narrator_assertions #(
  parameter int WORD_BUF_DEPTH = 2
) (
  input wire                               CLK_50M,
  input wire                               rst_n,
  input wire                               flash_read,
  input wire narrator_pkg::flash_addr_t    flash_address,
  input wire                               flash_waitrequest,
  input wire                               flash_readdatavalid,
  input wire                               req_valid,
  input wire                               pop,
  input wire [$clog2(WORD_BUF_DEPTH+1)-1:0] q_count,
  input wire [1:0]                         rd_state
);
  localparam int                 COUNT_W      = $clog2(WORD_BUF_DEPTH + 1);
  localparam logic [COUNT_W-1:0] DEPTH_C      = COUNT_W'(WORD_BUF_DEPTH);
  // Encodings of the reader FSM, in declaration order
  localparam logic [1:0]         ST_IDLE      = 2'd0;
  localparam logic [1:0]         ST_WAIT_DATA = 2'd2;

  // Words held by the reader, each one holds a credit
  logic [COUNT_W:0] held_words;

  assign held_words = {1'b0, q_count} + {{COUNT_W{1'b0}}, (rd_state != ST_IDLE)};

  // ========================================
  // Flash port rules
  // ========================================
  addr_stable: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address))
    else $error("flash_address or flash_read moved while waitrequest was high");

  valid_has_read: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_readdatavalid |-> (rd_state == ST_WAIT_DATA) || (flash_read && !flash_waitrequest))
    else $error("flash_readdatavalid arrived with no read outstanding");

  // Queue and credits
  queue_no_overflow: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    req_valid && !pop |-> q_count < DEPTH_C)
    else $error("request queue written while full");

  credits_in_range: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    held_words <= {1'b0, DEPTH_C})
    else $error("reader holds more words than there are credits");

endmodule

bind flash_word_reader narrator_assertions #(.WORD_BUF_DEPTH(WORD_BUF_DEPTH)) flash_checks (
  .CLK_50M             (CLK_50M),
  .rst_n               (rst_n),
  .flash_read          (flash_read),
  .flash_address       (flash_address),
  .flash_waitrequest   (flash_waitrequest),
  .flash_readdatavalid (flash_readdatavalid),
  .req_valid           (req_valid),
  .pop                 (pop),
  .q_count             (q_count),
  .rd_state            (state)
);
`default_nettype wire

//--- sim/narrator_tb.sv
`timescale 1ns/100ps
`default_nettype none
module narrator_tb;
  import narrator_pkg::*;

  localparam rate_div_t DIV_DEFAULT = 16'd8;
  localparam rate_div_t DIV_STEP    = 16'd2;
  localparam rate_div_t DIV_MIN     = 16'd4;
  localparam rate_div_t DIV_MAX     = 16'd20;
  localparam int        BUF_DEPTH   = 2;
  localparam int        NUM_ROWS    = 16;

  // Speed command bits are {reset, down, up}
  localparam logic [2:0] CMD_NONE  = 3'b000;
  localparam logic [2:0] CMD_UP    = 3'b001;
  localparam logic [2:0] CMD_DOWN  = 3'b010;
  localparam logic [2:0] CMD_RESET = 3'b100;

  typedef struct packed {
    phoneme_id_t id;
    logic [2:0]  cmd;
    rate_div_t   div;
  } row_t;

  typedef struct packed {
    sample_t value;
    logic    done;
  } expect_t;

  // ========================================
  // Stimulus table
  // ========================================
  // Expected divisor is the value right after the command
  localparam row_t ROWS [NUM_ROWS] = '{
    '{4'd1,  CMD_NONE,           16'd8},
    '{4'd5,  CMD_UP,             16'd6},
    '{4'd0,  CMD_UP,             16'd4},
    '{4'd3,  CMD_UP,             16'd4},
    '{4'd7,  CMD_DOWN,           16'd6},
    '{4'd15, CMD_UP | CMD_DOWN,  16'd4},
    '{4'd2,  CMD_RESET | CMD_UP, 16'd8},
    '{4'd11, CMD_DOWN,           16'd10},
    '{4'd14, CMD_DOWN,           16'd12},
    '{4'd0,  CMD_DOWN,           16'd14},
    '{4'd4,  CMD_DOWN,           16'd16},
    '{4'd13, CMD_DOWN,           16'd18},
    '{4'd6,  CMD_DOWN,           16'd20},
    '{4'd10, CMD_DOWN,           16'd20},
    '{4'd8,  CMD_RESET,          16'd8},
    '{4'd12, CMD_UP,             16'd6}
  };

  logic        CLK_50M;
  logic        rst_n;
  logic        phoneme_valid;
  phoneme_id_t phoneme_id;
  logic        phoneme_ready;
  logic        flash_read;
  flash_addr_t flash_address;
  logic        flash_waitrequest;
  flash_word_t flash_readdata;
  logic        flash_readdatavalid;
  logic        speed_up;
  logic        speed_down;
  logic        speed_reset;
  sample_t     sample_out;
  logic        sample_strobe;
  logic        phoneme_done;
  rate_div_t   sample_divisor;

  logic [31:0] lfsr;
  expect_t     exp_q [$];
  expect_t     want;
  flash_addr_t held_addr;
  rate_div_t   cur_div;
  rate_div_t   div_prev;
  logic        have_strobe;
  int          lat_left;
  int          cycle_count;
  int          timeout_limit;
  int          last_strobe;
  int          value_errors;
  int          other_errors;
  int          sample_count;
  int          done_count;
  int          flash_reads;
  int          exp_samples;
  int          exp_reads;

  narrator_top #(
    .SAMPLE_DIV_DEFAULT (DIV_DEFAULT),
    .SAMPLE_DIV_STEP    (DIV_STEP),
    .SAMPLE_DIV_MIN     (DIV_MIN),
    .SAMPLE_DIV_MAX     (DIV_MAX),
    .WORD_BUF_DEPTH     (BUF_DEPTH)
  ) uut (.*);

  always #10 CLK_50M = ~CLK_50M;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic next_rand_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic int word_count(input phoneme_id_t id);
    return 2 + int'(id[1:0]);
  endfunction

  // Byte k of flash word A holds A + 4k
  function automatic logic [7:0] flash_byte(input flash_addr_t addr, input int k);
    return addr[7:0] + 8'(4 * k);
  endfunction

  task automatic check_value(input string what, input int got, input int expected);
    if (got != expected)
    begin
      value_errors++;
      $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  task automatic queue_phoneme_samples(input phoneme_id_t id);
    flash_addr_t start;
    expect_t     e;
    start = flash_addr_t'({id, 6'd0});
    for (int w = 0; w < word_count(id); w++)
      for (int k = 0; k < 4; k++)
      begin
        e.value = (id == 4'd0) ? sample_t'(0) : sample_t'(flash_byte(start + flash_addr_t'(w), k));
        e.done  = (w == word_count(id) - 1) && (k == 3);
        exp_q.push_back(e);
      end
    exp_samples += 4 * word_count(id);
    if (id != 4'd0)
      exp_reads += word_count(id);
  endtask

  task automatic pulse_speed(input logic [2:0] cmd);
    {speed_reset, speed_down, speed_up} = cmd;
    @(posedge CLK_50M);
    #1;
    {speed_reset, speed_down, speed_up} = CMD_NONE;
  endtask

  task automatic offer_phoneme(input phoneme_id_t id);
    phoneme_id    = id;
    phoneme_valid = 1'b1;
    @(negedge CLK_50M);
    while (!phoneme_ready)
      @(negedge CLK_50M);
    @(posedge CLK_50M);
    #1;
    phoneme_valid = 1'b0;
  endtask

  // ========================================
  // Flash model
  // ========================================
  // Random stall cycles and then data 0 to 3 cycles after the accept
  always @(posedge CLK_50M)
  begin
    #1;
    flash_readdatavalid = 1'b0;
    if (!rst_n)
      lat_left = -1;
    else if (lat_left > 0)
      lat_left--;
    else if (flash_read)
    begin
      flash_waitrequest = next_rand_bit();
      if (!flash_waitrequest)
      begin
        held_addr = flash_address;
        flash_reads++;
        lat_left  = 2 * int'(next_rand_bit());
        lat_left += int'(next_rand_bit());
      end
    end
    else
      flash_waitrequest = 1'b1;
    if (lat_left == 0)
    begin
      flash_readdata      = {flash_byte(held_addr, 3), flash_byte(held_addr, 2),
                             flash_byte(held_addr, 1), flash_byte(held_addr, 0)};
      flash_readdatavalid = 1'b1;
      lat_left            = -1;
    end
  end

  // Sample monitor at mid cycle
  always @(negedge CLK_50M)
  begin
    if (rst_n && sample_strobe)
    begin
      sample_count++;
      if (exp_q.size() == 0)
      begin
        other_errors++;
        $display("Sample %0d at %0t came with nothing left to play", sample_out, $time);
      end
      else
      begin
        want = exp_q.pop_front();
        check_value("sample_out", int'($unsigned(sample_out)), int'($unsigned(want.value)));
        check_value("phoneme_done", int'(phoneme_done), int'(want.done));
      end
      if (have_strobe)
        check_value("strobe gap not below divisor",
                    int'(cycle_count - last_strobe >= int'(div_prev)), 1);
      have_strobe = 1'b1;
      last_strobe = cycle_count;
    end
    else if (rst_n && phoneme_done)
    begin
      other_errors++;
      $display("phoneme_done pulsed at %0t without a sample strobe", $time);
    end
    if (phoneme_done)
      done_count++;
    div_prev = cur_div;
  end

  always @(posedge CLK_50M)
  begin
    cycle_count++;
    if (cycle_count > timeout_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("test failed");
      $finish;
    end
  end

  initial
  begin
    CLK_50M             = 1'b0;
    rst_n               = 1'b0;
    phoneme_valid       = 1'b0;
    phoneme_id          = '0;
    flash_waitrequest   = 1'b1;
    flash_readdata      = '0;
    flash_readdatavalid = 1'b0;
    {speed_reset, speed_down, speed_up} = CMD_NONE;
    lfsr          = 32'h1f117e9e;
    lat_left      = -1;
    have_strobe   = 1'b0;
    cur_div       = DIV_DEFAULT;
    div_prev      = DIV_DEFAULT;
    cycle_count   = 0;
    last_strobe   = 0;
    value_errors  = 0;
    other_errors  = 0;
    sample_count  = 0;
    done_count    = 0;
    flash_reads   = 0;
    exp_samples   = 0;
    exp_reads     = 0;
    timeout_limit = 200;
    for (int r = 0; r < NUM_ROWS; r++)
      timeout_limit += word_count(ROWS[r].id) * 4 * int'(DIV_MAX);

    repeat (4) @(posedge CLK_50M);
    #1;
    check_value("divisor after reset", int'(sample_divisor), int'(DIV_DEFAULT));
    check_value("phoneme_ready after reset", int'(phoneme_ready), 1);
    check_value("sample_strobe after reset", int'(sample_strobe), 0);
    check_value("flash_read after reset", int'(flash_read), 0);
    rst_n = 1'b1;

    for (int r = 0; r < NUM_ROWS; r++)
    begin
      queue_phoneme_samples(ROWS[r].id);
      pulse_speed(ROWS[r].cmd);
      cur_div = ROWS[r].div;
      check_value("sample_divisor", int'(sample_divisor), int'(ROWS[r].div));
      offer_phoneme(ROWS[r].id);
    end

    // Drain and watch a while for stray samples
    while (exp_q.size() != 0)
      @(negedge CLK_50M);
    repeat (2 * int'(DIV_MAX)) @(negedge CLK_50M);
    check_value("sample count", sample_count, exp_samples);
    check_value("flash read count", flash_reads, exp_reads);
    check_value("phoneme_done count", done_count, NUM_ROWS);

    $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule
`default_nettype wire

//--- all.f
verilog/narrator_pkg.sv
verilog/sample_rate_ctrl.sv
verilog/phoneme_sequencer.sv
verilog/flash_word_reader.sv
verilog/sample_unpacker.sv
verilog/narrator_top.sv
sim/narrator_assertions.sv
sim/narrator_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the narrator testbench with Verilator and runs it into sim.log
rm -f sim.log
verilator --binary --timing --assert --top-module narrator_tb -f all.f -o narrator_sim \
  && ./obj_dir/narrator_sim > sim.log 2>&1
grep -qx "test passed" sim.log \
  && echo "Simulation passed, see sim.log" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
